// File: project.f
source/kitt_pkg.sv
source/scan_ctrl.sv
source/step_timer.sv
source/pwm_gen.sv
source/lamp_pattern.sv
source/lamp_driver.sv
source/kitt_scanner.sv
verif/kitt_scanner_props.sv
verif/kitt_scanner_tb.sv

// File: verif/kitt_scanner_tb.sv
module kitt_scanner_tb import kitt_pkg::*; ();

    localparam int go_timeout   = 20000;                  // idle cycles of the compare process
    localparam int scan_timeout = 30 * step_slow_cycles;
    localparam int lit_timeout  = 4 * step_slow_cycles + 20;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic       speed;
    logic [1:0] mode;
    logic       oinv;
    logic       osel;
    lamp_vec_t  led;

    integer     seed;
    logic       cmp_go = 1'b0;    // stimulus to compare process
    logic       cmp_done = 1'b0;  // compare process back to stimulus
    string      cmp_name;
    scan_mode_t cmp_mode;
    logic       cmp_fast;
    lamp_vec_t  cmp_mask;

    kitt_scanner kitt_scanner_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (ena),
        .speed (speed),
        .mode  (mode),
        .oinv  (oinv),
        .osel  (osel),
        .led   (led)
    );

    always #20 clk = ~clk;

    // start pattern followed by the repeating cycle of each mode
    function automatic lamp_vec_t expected_lamps(input scan_mode_t m, input int step);
        lamp_vec_t bounce_seq [22] = '{8'h03, 8'h07, 8'h0f, 8'h1e, 8'h3c, 8'h78, 8'hf0, 8'he0,
                                       8'hc0, 8'h80, 8'h80, 8'hc0, 8'he0, 8'hf0, 8'h78, 8'h3c,
                                       8'h1e, 8'h0f, 8'h07, 8'h03, 8'h01, 8'h01};
        lamp_vec_t converge_seq [9] = '{8'h81, 8'hc3, 8'h66, 8'h3c, 8'h18, 8'h18, 8'h3c, 8'h66,
                                        8'h81};
        lamp_vec_t sweep_seq [10] = '{8'h80, 8'h40, 8'h20, 8'h10, 8'h08, 8'h04, 8'h02, 8'h01,
                                      8'h00, 8'h00};
        lamp_vec_t result;
        case (m)
            mode_converge: result = (step == 0) ? 8'h81 : converge_seq[(step - 1) % 9];
            mode_sweep:    result = (step == 0) ? 8'h00 : sweep_seq[(step - 1) % 10];
            default:       result = (step == 0) ? 8'h01 : bounce_seq[(step - 1) % 22];
        endcase
        return result;
    endfunction

    // first step whose output differs from the dark idle output
    function automatic int first_lit_step(input scan_mode_t m, input lamp_vec_t mask);
        int s;
        s = 0;
        while (s < 4 && (expected_lamps(m, s) ^ mask) == 8'h00) begin
            s++;
        end
        return s;
    endfunction

    function automatic int next_diff_step(input scan_mode_t m, input int s0);
        int s;
        s = s0 + 1;
        while (s < s0 + 4 && expected_lamps(m, s) == expected_lamps(m, s0)) begin
            s++;
        end
        return s;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_lamps(input string name, input lamp_vec_t expected,
                               input lamp_vec_t actual);
        if (actual !== expected) begin
            $display("** Error [%s] expected %h, actual %h", name, expected, actual);
            fail_run("lamp output mismatch");
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("** Error [%s] expected %0d, actual %0d", name, expected, actual);
            fail_run("cycle count mismatch");
        end
    endtask

    always @(negedge clk) begin
        if (kitt_scanner_inst.kitt_scanner_props_inst.fail_count != 0) begin
            fail_run("a concurrent assertion on the DUT failed");
        end
    end

    // led must be dark two cycles after ena drops at a falling edge
    task automatic drop_enable();
        ena = 1'b0;
        repeat (2) @(negedge clk);
        check_lamps("led cleared after disable", 8'h00, led);
    endtask

    task automatic run_scan(input string name, input scan_mode_t m, input logic fast,
                            input logic inv);
        int waited;
        mode     = m;
        speed    = fast;
        oinv     = inv;
        osel     = 1'b0;
        ena      = 1'b1;
        cmp_name = name;
        cmp_mode = m;
        cmp_fast = fast;
        cmp_mask = {num_lamps{inv}};
        cmp_go   = 1'b1;
        waited   = 0;
        while (!cmp_done) begin
            @(negedge clk);
            waited++;
            if (waited > scan_timeout) fail_run({name, ": compare process did not finish"});
        end
        cmp_go = 1'b0;
        waited = 0;
        while (cmp_done) begin
            @(negedge clk);
            waited++;
            if (waited > 10) fail_run({name, ": compare process did not return to idle"});
        end
    endtask

    task automatic measure_pwm(input logic fast);
        int waited;
        int high_cnt [num_lamps];
        int duty_exp [num_lamps] = '{4, 9, 24, 100, 0, 0, 0, 0};  // lamp 0 first
        mode   = mode_bounce;
        speed  = fast;
        oinv   = 1'b0;
        osel   = 1'b1;
        ena    = 1'b1;
        waited = 0;
        while (led[3] !== 1'b1) begin  // lamp 3 lights first in the 0f step
            @(negedge clk);
            waited++;
            if (waited > lit_timeout) fail_run("pwm test: step with pattern 0f never came");
        end
        repeat (200) @(negedge clk);
        foreach (high_cnt[i]) high_cnt[i] = 0;
        repeat (pwm_period) begin
            @(negedge clk);
            for (int i = 0; i < num_lamps; i++) high_cnt[i] += led[i];
        end
        for (int i = 0; i < num_lamps; i++) begin
            check_count($sformatf("pwm high cycles lamp %0d", i), duty_exp[i], high_cnt[i]);
        end
        drop_enable();
    endtask

    initial begin : compare_proc
        int period;
        int s0;
        int s1;
        int half;
        int total;
        int sample_n;
        int waited;
        lamp_vec_t first_val;
        bit seen_next;
        forever begin
            waited = 0;
            while (!cmp_go) begin
                @(negedge clk);
                waited++;
                if (waited > go_timeout) fail_run("compare process was never started");
            end
            period = cmp_fast ? step_fast_cycles : step_slow_cycles;
            s0     = first_lit_step(cmp_mode, cmp_mask);
            s1     = next_diff_step(cmp_mode, s0);
            waited = 0;
            while (led === 8'h00) begin  // first led change after enable
                @(negedge clk);
                waited++;
                if (waited > lit_timeout) fail_run({cmp_name, ": led never left idle"});
            end
            first_val = led;
            half      = period / 2;
            total     = half + 24 * period;
            seen_next = 1'b0;
            sample_n  = 0;
            for (int c = 1; c <= total; c++) begin
                @(negedge clk);
                if (!seen_next && led !== first_val) begin
                    check_count({cmp_name, " step period"}, period * (s1 - s0), c);
                    seen_next = 1'b1;
                end
                if (c == half + sample_n * period) begin  // middle of each step
                    check_lamps($sformatf("%s step %0d", cmp_name, s0 + sample_n),
                                expected_lamps(cmp_mode, s0 + sample_n) ^ cmp_mask, led);
                    sample_n++;
                end
            end
            cmp_done = 1'b1;
            waited   = 0;
            while (cmp_go) begin
                @(negedge clk);
                waited++;
                if (waited > 10) fail_run("stimulus did not release the compare process");
            end
            cmp_done = 1'b0;
        end
    end

    initial begin
        int pick;
        seed  = 32'hcba2;
        clk   = 1'b0;
        rst_n = 1'b0;
        ena   = 1'b0;
        speed = 1'b0;
        mode  = 2'd0;
        oinv  = 1'b0;
        osel  = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        repeat (40) begin
            @(negedge clk);
            check_lamps("idle after reset", 8'h00, led);
        end

        for (int m = 0; m < 3; m++) begin
            for (int sp = 0; sp < 2; sp++) begin
                run_scan($sformatf("mode %0d speed %0d", m, sp), scan_mode_t'(m), sp[0], 1'b0);
                drop_enable();
            end
        end

        for (int m = 0; m < 3; m++) begin  // inverted output at a random speed
            pick = $random(seed) & 1;
            run_scan($sformatf("mode %0d inverted", m), scan_mode_t'(m), pick[0], 1'b1);
            drop_enable();
        end

        pick = $random(seed) & 1;
        measure_pwm(pick[0]);

        // restart in the middle of a bounce scan with a different mode
        mode  = mode_bounce;
        speed = 1'b1;
        osel  = 1'b0;
        oinv  = 1'b0;
        ena   = 1'b1;
        pick  = 0;
        while (led !== 8'h0f) begin
            @(negedge clk);
            pick++;
            if (pick > lit_timeout) fail_run("restart test: bounce scan did not reach 0f");
        end
        pick = $unsigned($random(seed)) % 1000;
        repeat (pick) @(negedge clk);
        drop_enable();
        pick = 1 + $unsigned($random(seed)) % 3;  // code 3 should run bounce
        run_scan($sformatf("restart mode %0d", pick), scan_mode_t'(pick), 1'b1, 1'b0);
        drop_enable();

        @(negedge clk);
        if (kitt_scanner_inst.kitt_scanner_props_inst.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            fail_run("a concurrent assertion on the DUT failed");
        end
    end

endmodule

// File: verif/kitt_scanner_props.sv
module kitt_scanner_props import kitt_pkg::*; (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 ena,
    input logic                 step_run,
    input logic                 step_done,
    input logic                 out_sel,
    input scan_state_t          state,
    input duty_vec_t            duty,
    input logic [pwm_cnt_w-1:0] pwm_cnt,
    input lamp_vec_t            led
);

    int fail_count = 0;  // read by the testbench

    // prescaler starts from zero so no step ends during capture
    done_only_when_running: assert property (@(posedge clk) disable iff (!rst_n)
        step_done |-> (step_run ? (state == st_run) : (state == st_idle)))
    else begin
        $error("step_done high outside the run and idle states");
        fail_count++;
    end

    // plain lamp output moves one cycle after the step op, or on enable changes
    led_steady_between_steps: assert property (@(posedge clk) disable iff (!rst_n)
        ($changed(led) && !out_sel) |-> ($past(step_done, 2) || !$past(ena) || !$past(ena, 2)))
    else begin
        $error("led changed between step boundaries");
        fail_count++;
    end

    // pwm frame starts over from zero on every run
    pwm_off_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_idle) |=> (pwm_cnt == '0 && duty == '0))
    else begin
        $error("pwm counter or duty strobes active after idle");
        fail_count++;
    end

endmodule

bind kitt_scanner kitt_scanner_props kitt_scanner_props_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ena       (ena),
    .step_run  (step_run),
    .step_done (step_done),
    .out_sel   (out_sel),
    .state     (scan_ctrl_inst.state),
    .duty      (duty),
    .pwm_cnt   (pwm_gen_inst.cnt),
    .led       (led)
);

// File: source/kitt_scanner.sv
module kitt_scanner import kitt_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ena,
    input  logic       speed,
    input  logic [1:0] mode,
    input  logic       oinv,
    input  logic       osel,
    output lamp_vec_t  led
);

    logic         step_run;
    logic         step_fast;
    logic         step_done;
    logic         pwm_run;
    logic         out_sel;
    logic         out_inv;
    pattern_op_t  pat_op;
    pattern_id_t  pat_id;
    duty_vec_t    duty;
    lamp_vec_t    lamps;
    level_array_t levels;

    scan_ctrl scan_ctrl_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ena       (ena),
        .speed     (speed),
        .mode      (scan_mode_t'(mode)),
        .oinv      (oinv),
        .osel      (osel),
        .step_done (step_done),
        .step_run  (step_run),
        .step_fast (step_fast),
        .pwm_run   (pwm_run),
        .pat_op    (pat_op),
        .pat_id    (pat_id),
        .out_sel   (out_sel),
        .out_inv   (out_inv)
    );

    step_timer step_timer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .run       (step_run),
        .fast      (step_fast),
        .step_done (step_done)
    );

    pwm_gen pwm_gen_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .run   (pwm_run),
        .duty  (duty)
    );

    lamp_pattern lamp_pattern_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (pat_op),
        .id     (pat_id),
        .lamps  (lamps),
        .levels (levels)
    );

    lamp_driver lamp_driver_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .lamps  (lamps),
        .levels (levels),
        .duty   (duty),
        .sel    (out_sel),
        .inv    (out_inv),
        .led    (led)
    );

endmodule

// File: source/lamp_driver.sv
module lamp_driver import kitt_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  lamp_vec_t    lamps,
    input  level_array_t levels,
    input  duty_vec_t    duty,
    input  logic         sel,
    input  logic         inv,
    output lamp_vec_t    led
);

    lamp_vec_t pwm_nxt;
    lamp_vec_t pwm_q;
    lamp_vec_t lamp_q;

    always_comb begin
        for (int i = 0; i < num_lamps; i++) begin
            case (levels[i])
                level_full: pwm_nxt[i] = 1'b1;
                level_25:   pwm_nxt[i] = duty[duty_bit_25];
                level_10:   pwm_nxt[i] = duty[duty_bit_10];
                level_05:   pwm_nxt[i] = duty[duty_bit_05];
                default:    pwm_nxt[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_q  <= '0;
            lamp_q <= '0;
        end else begin
            pwm_q  <= pwm_nxt;
            lamp_q <= lamps;
        end
    end

    assign led = {num_lamps{inv}} ^ (sel ? pwm_q : lamp_q);

endmodule

// File: source/lamp_pattern.sv
module lamp_pattern import kitt_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  pattern_op_t  op,
    input  pattern_id_t  id,
    output lamp_vec_t    lamps,
    output level_array_t levels
);

    localparam int half = num_lamps / 2;

    lamp_vec_t    pre_lamps;
    level_array_t pre_levels;
    lamp_vec_t    lamps_nxt;
    level_array_t levels_nxt;

    always_comb begin
        case (id)
            pat_bounce_start:      pre_lamps = 8'h01;
            pat_bounce_2:          pre_lamps = 8'h03;
            pat_bounce_3:          pre_lamps = 8'h07;
            pat_bounce_4:          pre_lamps = 8'h0f;
            pat_bounce_top:        pre_lamps = 8'h80;
            pat_bounce_top_2:      pre_lamps = 8'hc0;
            pat_bounce_top_3:      pre_lamps = 8'he0;
            pat_bounce_top_4:      pre_lamps = 8'hf0;
            pat_bounce_bottom:     pre_lamps = 8'h01;
            pat_converge_edge:     pre_lamps = 8'h81;
            pat_converge_edge_2:   pre_lamps = 8'hc3;
            pat_converge_center:   pre_lamps = 8'h18;
            pat_converge_center_2: pre_lamps = 8'h3c;
            pat_sweep_top:         pre_lamps = 8'h80;
            pat_sweep_top_2:       pre_lamps = 8'h40;  // lamp 7 dim in pwm only
            default:               pre_lamps = 8'h00;
        endcase
    end

    // levels listed from lamp 7 down to lamp 0
    always_comb begin
        pre_levels = levels_dark;
        case (id)
            pat_bounce_start:  pre_levels[0] = level_full;
            pat_bounce_2:      pre_levels[1:0] = {level_full, level_25};
            pat_bounce_3:      pre_levels[2:0] = {level_full, level_25, level_10};
            pat_bounce_4:      pre_levels[3:0] = {level_full, level_25, level_10, level_05};
            pat_bounce_top:    pre_levels[7] = level_full;
            pat_bounce_top_2:  pre_levels[7:6] = {level_25, level_full};
            pat_bounce_top_3:  pre_levels[7:5] = {level_10, level_25, level_full};
            pat_bounce_top_4:  pre_levels[7:4] = {level_05, level_10, level_25, level_full};
            pat_bounce_bottom: pre_levels[0] = level_05;  // fading tail at the bottom
            pat_converge_edge: begin
                pre_levels[7] = level_full;
                pre_levels[0] = level_full;
            end
            pat_converge_edge_2: begin
                pre_levels[7:6] = {level_10, level_full};
                pre_levels[1:0] = {level_full, level_10};
            end
            pat_converge_center:   pre_levels[4:3] = {level_full, level_full};
            pat_converge_center_2: pre_levels[5:2] = {level_full, level_10, level_10, level_full};
            pat_sweep_top:         pre_levels[7] = level_full;
            pat_sweep_top_2:       pre_levels[7:6] = {level_10, level_full};
            default:               pre_levels = levels_dark;
        endcase
    end

    always_comb begin
        lamps_nxt  = '0;  // vacated lamps go dark
        levels_nxt = levels_dark;
        case (op)
            op_hold: begin
                lamps_nxt  = lamps;
                levels_nxt = levels;
            end
            op_load: begin
                lamps_nxt  = pre_lamps;
                levels_nxt = pre_levels;
            end
            op_shift_up: begin
                for (int i = 1; i < num_lamps; i++) begin
                    lamps_nxt[i]  = lamps[i-1];
                    levels_nxt[i] = levels[i-1];
                end
            end
            op_shift_down: begin
                for (int i = 0; i < num_lamps - 1; i++) begin
                    lamps_nxt[i]  = lamps[i+1];
                    levels_nxt[i] = levels[i+1];
                end
            end
            op_converge: begin
                for (int i = 1; i < half; i++) begin
                    lamps_nxt[i]  = lamps[i-1];
                    levels_nxt[i] = levels[i-1];
                end
                for (int i = half; i < num_lamps - 1; i++) begin
                    lamps_nxt[i]  = lamps[i+1];
                    levels_nxt[i] = levels[i+1];
                end
            end
            op_diverge: begin
                for (int i = 0; i < half - 1; i++) begin
                    lamps_nxt[i]  = lamps[i+1];
                    levels_nxt[i] = levels[i+1];
                end
                for (int i = half + 1; i < num_lamps; i++) begin
                    lamps_nxt[i]  = lamps[i-1];
                    levels_nxt[i] = levels[i-1];
                end
            end
            default: lamps_nxt = '0;  // clear
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lamps  <= '0;
            levels <= levels_dark;
        end else begin
            lamps  <= lamps_nxt;
            levels <= levels_nxt;
        end
    end

endmodule

// File: source/pwm_gen.sv
module pwm_gen import kitt_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      run,
    output duty_vec_t duty
);

    logic [pwm_cnt_w-1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run || cnt == pwm_cnt_w'(pwm_period - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // strobes lead the registered lamp bits by one cycle
    always_comb begin
        duty              = '0;
        duty[duty_bit_25] = run && (cnt < pwm_cnt_w'(duty_25_cycles));
        duty[duty_bit_10] = run && (cnt < pwm_cnt_w'(duty_10_cycles));
        duty[duty_bit_05] = run && (cnt < pwm_cnt_w'(duty_05_cycles));
    end

endmodule

// File: source/step_timer.sv
module step_timer import kitt_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic run,
    input  logic fast,
    output logic step_done
);

    logic [step_cnt_w-1:0] cnt;
    logic [step_cnt_w-1:0] cnt_last;

    assign cnt_last = fast ? step_cnt_w'(step_fast_cycles - 1)
                           : step_cnt_w'(step_slow_cycles - 1);

    assign step_done = !run || (cnt == cnt_last);  // stays high while stopped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (!run || cnt >= cnt_last) begin
            cnt <= '0;  // also catches a speed change mid-step
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// File: source/scan_ctrl.sv
module scan_ctrl import kitt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ena,
    input  logic        speed,
    input  scan_mode_t  mode,
    input  logic        oinv,
    input  logic        osel,
    input  logic        step_done,
    output logic        step_run,
    output logic        step_fast,
    output logic        pwm_run,
    output pattern_op_t pat_op,
    output pattern_id_t pat_id,
    output logic        out_sel,
    output logic        out_inv
);

    scan_state_t             state;
    scan_state_t             state_nxt;
    scan_mode_t              mode_q;
    logic [step_idx_w-1:0]   step_idx;
    logic [step_idx_w-1:0]   step_last;
    pattern_op_t             seq_op;
    pattern_id_t             seq_id;
    pattern_id_t             start_id;

    assign step_run = (state != st_idle);  // prescaler starts counting in capture
    assign pwm_run  = (state == st_run);

    always_comb begin
        case (state)
            st_idle:    state_nxt = st_capture;
            st_capture: state_nxt = st_run;
            default:    state_nxt = st_run;
        endcase
        if (!ena) begin
            state_nxt = st_idle;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            mode_q    <= mode_bounce;
            step_fast <= 1'b0;
            out_sel   <= 1'b0;
            out_inv   <= 1'b0;
            step_idx  <= '0;
        end else begin
            state <= state_nxt;
            if (!ena) begin
                out_sel <= 1'b0;  // dark, non-inverted output while idle
                out_inv <= 1'b0;
            end else if (state == st_capture) begin
                mode_q    <= mode;
                step_fast <= speed;
                out_sel   <= osel;
                out_inv   <= oinv;
            end
            if (state != st_run) begin
                step_idx <= '0;
            end else if (step_done) begin
                step_idx <= (step_idx == step_last) ? '0 : step_idx + 1'b1;
            end
        end
    end

    // start preset follows the live mode input, it is loaded before capture
    always_comb begin
        case (mode)
            mode_converge: start_id = pat_converge_edge;
            mode_sweep:    start_id = pat_dark;
            default:       start_id = pat_bounce_start;
        endcase
    end

    // per-step sequence of the captured mode
    always_comb begin
        seq_op = op_load;
        seq_id = pat_dark;
        case (mode_q)
            mode_converge: begin
                step_last = step_idx_w'(converge_steps - 1);
                case (step_idx) inside
                    0, 8:    seq_id = pat_converge_edge;
                    1:       seq_id = pat_converge_edge_2;
                    [2:4]:   seq_op = op_converge;
                    5:       seq_id = pat_converge_center;
                    6:       seq_id = pat_converge_center_2;
                    7:       seq_op = op_diverge;
                    default: seq_op = op_hold;
                endcase
            end
            mode_sweep: begin
                step_last = step_idx_w'(sweep_steps - 1);
                case (step_idx) inside
                    0:       seq_id = pat_sweep_top;
                    1:       seq_id = pat_sweep_top_2;  // dim trail above the dot
                    [2:8]:   seq_op = op_shift_down;
                    9:       seq_id = pat_dark;
                    default: seq_op = op_hold;
                endcase
            end
            default: begin
                step_last = step_idx_w'(bounce_steps - 1);
                case (step_idx) inside
                    0:       seq_id = pat_bounce_2;
                    1:       seq_id = pat_bounce_3;
                    2:       seq_id = pat_bounce_4;
                    [3:9]:   seq_op = op_shift_up;     // bar runs to the top
                    10:      seq_id = pat_bounce_top;
                    11:      seq_id = pat_bounce_top_2;
                    12:      seq_id = pat_bounce_top_3;
                    13:      seq_id = pat_bounce_top_4;
                    [14:20]: seq_op = op_shift_down;   // and back down
                    21:      seq_id = pat_bounce_bottom;
                    default: seq_op = op_hold;
                endcase
            end
        endcase
    end

    always_comb begin
        pat_op = op_hold;
        pat_id = pat_dark;
        if (!ena) begin
            pat_op = op_clear;
        end else if (state == st_idle) begin
            pat_op = op_load;
            pat_id = start_id;
        end else if (state == st_run && step_done) begin
            pat_op = seq_op;
            pat_id = seq_id;
        end
    end

endmodule

// File: source/kitt_pkg.sv
package kitt_pkg;

    localparam int num_lamps        = 8;
    localparam int pwm_period       = 100;   // clocks per pwm frame
    localparam int duty_25_cycles   = 24;
    localparam int duty_10_cycles   = 9;
    localparam int duty_05_cycles   = 4;
    localparam int step_slow_cycles = 1500;  // clocks per scan step
    localparam int step_fast_cycles = 1000;
    localparam int step_cnt_w       = $clog2(step_slow_cycles);
    localparam int pwm_cnt_w        = $clog2(pwm_period);

    // steps in one repeating cycle of each mode
    localparam int bounce_steps   = 22;
    localparam int converge_steps = 9;
    localparam int sweep_steps    = 10;
    localparam int step_idx_w     = $clog2(bounce_steps);

    localparam int duty_bit_25 = 0;  // strobe positions in duty_vec_t
    localparam int duty_bit_10 = 1;
    localparam int duty_bit_05 = 2;

    typedef logic [num_lamps-1:0] lamp_vec_t;
    typedef logic [2:0]           duty_vec_t;

    typedef enum logic [2:0] {
        level_full = 3'd0,
        level_25   = 3'd1,
        level_10   = 3'd2,
        level_05   = 3'd3,
        level_off  = 3'd4
    } lamp_level_t;

    typedef lamp_level_t [num_lamps-1:0] level_array_t;

    localparam level_array_t levels_dark = level_array_t'({num_lamps{level_off}});

    typedef enum logic [1:0] {
        mode_bounce   = 2'd0,
        mode_converge = 2'd1,
        mode_sweep    = 2'd2,
        mode_alt      = 2'd3   // runs the bounce sequence
    } scan_mode_t;

    typedef enum logic [1:0] {st_idle, st_capture, st_run} scan_state_t;

    typedef enum logic [2:0] {
        op_hold, op_clear, op_load, op_shift_up, op_shift_down, op_converge, op_diverge
    } pattern_op_t;

    typedef enum logic [3:0] {
        pat_bounce_start, pat_bounce_2, pat_bounce_3, pat_bounce_4,
        pat_bounce_top, pat_bounce_top_2, pat_bounce_top_3, pat_bounce_top_4,
        pat_bounce_bottom, pat_converge_edge, pat_converge_edge_2, pat_converge_center,
        pat_converge_center_2, pat_sweep_top, pat_sweep_top_2, pat_dark
    } pattern_id_t;

endpackage
